// ==== run.sh ====
#!/bin/sh
# Builds the SRAM demo testbench with Verilator, runs it and checks the log

rm -rf obj_dir build.log sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module sramDemoTb \
	-f sim.f -o sramDemoSim > build.log 2>&1 \
	|| { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/sramDemoSim > sim.log 2>&1 || true
cat sim.log

# A run counts as passed only without the fail message and with the pass message
! grep -q "Some tests failed" sim.log && grep -q "All tests passed" sim.log \
	&& { echo "PASS"; exit 0; } \
	|| { echo "FAIL"; exit 1; }

// ==== sim.f ====
sramPkg.sv
tickGen.sv
sramModel.sv
sramController.sv
sramDemo.sv
sramDemoTb.sv

// ==== sramController.sv ====
/*
  Controller for the SRAM demo.
  Synchronizes the push buttons and runs the write and read passes over the
  first 128 words, one FSM step per tick. Read data shows on ledr[9:2] and
  status on ledr[1:0].
*/
module sramController (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         tick,
	input  logic [3:0]                   key,
	input  logic [sramPkg::dataBits-1:0] readData,
	output logic [sramPkg::addrBits-1:0] addr,
	output logic [sramPkg::dataBits-1:0] writeData,
	output logic                         oeN,
	output logic                         weN,
	output logic [sramPkg::ledCount-1:0] ledr
);

	// Two-flop synchronizer, only the read and write buttons matter
	logic [1:0] keyMeta;
	logic [1:0] keySync;

	logic enterRead;
	logic enterWrite;
	logic lastWord;

	logic [sramPkg::stateBits-1:0] state;

	always_ff @(posedge clk) begin
		if (rst) begin
			// Buttons idle high
			keyMeta <= 2'b11;
			keySync <= 2'b11;
		end else begin
			keyMeta <= key[1:0];
			keySync <= keyMeta;
		end
	end

	// Buttons are active low
	// Read wins when both are down
	assign enterRead = ~keySync[0];
	assign enterWrite = ~keySync[1] & ~enterRead;

	// End of a pass
	assign lastWord = (addr == sramPkg::lastAddr);

	// Main FSM, steps only on ticks
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= sramPkg::idle;
			ledr <= sramPkg::ledReset;
			addr <= '0;
			oeN <= 1'b1;
			weN <= 1'b1;
		end else if (tick) begin
			case (state)
				sramPkg::idle: begin
					if (enterRead) begin
						// Output enabled for the whole read pass
						ledr <= '0;
						addr <= '0;
						oeN <= 1'b0;
						weN <= 1'b1;
						state <= sramPkg::readDo;
					end else if (enterWrite) begin
						// First write strobe goes out with address 0
						ledr <= sramPkg::ledWrite;
						addr <= '0;
						oeN <= 1'b1;
						weN <= 1'b0;
						state <= sramPkg::writeDo;
					end else begin
						// Waiting for a button
						ledr <= sramPkg::ledIdle;
					end
				end

				// Word is being written, release the strobe
				sramPkg::writeDo: begin
					weN <= 1'b1;
					state <= sramPkg::writeSet;
				end

				// Move on to the next word or finish
				sramPkg::writeSet: begin
					if (lastWord) begin
						state <= sramPkg::idle;
					end else begin
						addr <= addr + 1'b1;
						weN <= 1'b0;
						state <= sramPkg::writeDo;
					end
				end

				// Latch the low byte onto the LEDs
				sramPkg::readDo: begin
					ledr[sramPkg::ledCount-1:2] <= readData[7:0];
					state <= sramPkg::readSet;
				end

				// Next address, or wrap to 0 and stop
				sramPkg::readSet: begin
					if (lastWord) begin
						addr <= '0;
						oeN <= 1'b1;
						state <= sramPkg::idle;
					end else begin
						addr <= addr + 1'b1;
						state <= sramPkg::readDo;
					end
				end

				default: begin
					state <= sramPkg::idle;
				end
			endcase
		end
	end

	// Write value, loaded at the start of a write pass and stepped down per word
	// Only meaningful while weN is low
	always_ff @(posedge clk) begin
		if (tick) begin
			if (state == sramPkg::idle && enterWrite) begin
				writeData <= sramPkg::writeStart;
			end else if (state == sramPkg::writeSet && !lastWord) begin
				writeData <= writeData - 1'b1;
			end
		end
	end

endmodule

// ==== sramDemo.sv ====
/*
  Top level of the SRAM demonstrator.
  Joins the tick generator, the controller and the RAM model on one clock.
  key[1] starts a write pass, key[0] a read pass; results show on ledr.
*/
module sramDemo #(
	parameter int tickBits = sramPkg::tickBitsDefault
) (
	input  logic                         clk,
	input  logic                         rst,
	input  logic [3:0]                   key,
	output logic [sramPkg::ledCount-1:0] ledr
);

	logic tick;

	// Controller side of the RAM
	logic [sramPkg::addrBits-1:0] addr;
	logic [sramPkg::dataBits-1:0] writeData;
	logic [sramPkg::dataBits-1:0] readData;
	logic oeN;
	logic weN;

	// Sets the pace of the FSM
	tickGen #(
		.tickBits(tickBits)
	) tickGen0 (
		.clk (clk),
		.rst (rst),
		.tick(tick)
	);

	sramController ctrl (
		.clk      (clk),
		.rst      (rst),
		.tick     (tick),
		.key      (key),
		.readData (readData),
		.addr     (addr),
		.writeData(writeData),
		.oeN      (oeN),
		.weN      (weN),
		.ledr     (ledr)
	);

	// Separate read and write buses stand in for the shared data pins
	sramModel ram (
		.clk      (clk),
		.addr     (addr),
		.writeData(writeData),
		.oeN      (oeN),
		.weN      (weN),
		.readData (readData)
	);

endmodule

// ==== sramDemoTb.sv ====
/*
  Directed testbench for the SRAM demonstrator top level.
  Runs write and read passes through the push buttons and checks ledr at every tick.
  The tick period is 4 clocks since the DUT is built with tickBits = 2.
*/
module sramDemoTb;

	timeunit 1ns;
	timeprecision 1ps;

	// Clock period in ns
	localparam int clockPeriod = 100;

	// Clocks per tick with tickBits = 2
	localparam int tickClocks = 4;

	// Two ticks per address over the demo range
	localparam int passTicks = 2 * (int'(sramPkg::lastAddr) + 1);

	// Ticks a button stays down
	localparam int keyHoldTicks = 3;

	// Status codes on ledr[1:0]
	localparam logic [sramPkg::ledCount-1:0] ledResetCode = 10'd1;
	localparam logic [sramPkg::ledCount-1:0] ledIdleCode = 10'd2;
	localparam logic [sramPkg::ledCount-1:0] ledWriteCode = 10'd3;

	// Button masks, a set bit means that button is held down
	localparam logic [3:0] noKey = 4'b0000;
	localparam logic [3:0] readKey = 4'b0001;
	localparam logic [3:0] writeKey = 4'b0010;
	localparam logic [3:0] keysIdle = 4'hF;

	// Ticks of all tests
	// Seven full passes with their start and idle ticks, five idle checks
	// and the cut-short read of 42 ticks
	// About three ticks for each of the two resets
	localparam int totalTicks = 7 * (passTicks + 2) + 5 + 42 + 2 * 3;

	// Watchdog limit, twice the expected run time
	localparam longint watchdogNs = longint'(totalTicks) * tickClocks * clockPeriod * 2;

	logic clk;
	logic rst;
	logic [3:0] key;
	logic [sramPkg::ledCount-1:0] ledr;

	// DUT, one tick every 4 clocks
	sramDemo #(
		.tickBits(2)
	) uut (
		.clk (clk),
		.rst (rst),
		.key (key),
		.ledr(ledr)
	);

	// Free-running clock
	initial begin
		clk = 1'b0;
		forever #(clockPeriod / 2) clk = ~clk;
	end

	// Ends the run with the fail message
	task automatic abortRun();
		$display("Some tests failed");
		$fatal(1, "simulation stopped on the first failure");
	endtask

	// Compares ledr with its expected value
	task automatic checkValue(
		input logic [sramPkg::ledCount-1:0] actual,
		input logic [sramPkg::ledCount-1:0] expected,
		input string what
	);
		if (actual !== expected) begin
			$display("error at %0t: %s, got %h expected %h", $time, what, actual, expected);
			abortRun();
		end
	endtask

	// Watchdog against a stuck FSM or a lost tick
	initial begin
		#(watchdogNs);
		$display("Timeout: the tests did not finish within %0d ns", watchdogNs);
		abortRun();
	end

	// Active-low button levels for tick i of a pass
	// own is held for the first ticks, other over a window from otherFrom
	function automatic logic [3:0] keysAt(
		input int i,
		input logic [3:0] own,
		input logic [3:0] other,
		input int otherFrom
	);
		logic [3:0] down;
		down = noKey;
		if (i < keyHoldTicks) begin
			down = down | own;
		end
		if (i >= otherFrom && i < otherFrom + keyHoldTicks) begin
			down = down | other;
		end
		return ~down;
	endfunction

	// LED pattern after address a is read
	// Address a holds writeStart minus a, its low byte sits on ledr[9:2]
	function automatic logic [sramPkg::ledCount-1:0] expectedLed(input int a);
		logic [sramPkg::dataBits-1:0] word;
		word = sramPkg::writeStart;
		word = word - a[sramPkg::dataBits-1:0];
		return {word[7:0], 2'b00};
	endfunction

	// One tick period
	// Buttons change on the first edge so the synchronizer settles before the tick
	// Returns at the falling edge after the tick edge
	task automatic advanceTick(input logic [3:0] keys);
		@(posedge clk);
		key <= keys;
		repeat (tickClocks - 1) @(posedge clk);
		@(negedge clk);
	endtask

	// Holds rst for five edges in all and releases it
	// Expects rst to be set already
	task automatic holdReset();
		repeat (4) @(posedge clk);
		@(negedge clk);
		checkValue(ledr, ledResetCode, "ledr during reset");
		@(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		checkValue(ledr, ledResetCode, "ledr just after reset");
	endtask

	// Write pass started by own, with other pressed over a window
	task automatic runWritePass(
		input logic [3:0] own,
		input logic [3:0] other,
		input int otherFrom
	);
		// Start tick, the FSM leaves idle here
		advanceTick(keysAt(0, own, other, otherFrom));
		checkValue(ledr, ledWriteCode, "ledr at start of write pass");

		// writeDo and writeSet per address
		// The last writeSet goes back to idle and leaves the LEDs alone
		for (int i = 1; i <= passTicks; i++) begin
			advanceTick(keysAt(i, own, other, otherFrom));
			checkValue(ledr, ledWriteCode, $sformatf("ledr at write tick %0d", i));
		end

		// First tick in idle again
		advanceTick(keysIdle);
		checkValue(ledr, ledIdleCode, "ledr after write pass");
	endtask

	// Read pass started by own, run for the given number of ticks
	// A full pass also checks the return to idle
	task automatic runReadPass(
		input logic [3:0] own,
		input logic [3:0] other,
		input int otherFrom,
		input int ticks
	);
		int addr;
		logic [sramPkg::ledCount-1:0] shown;

		// LEDs are cleared as the pass starts
		advanceTick(keysAt(0, own, other, otherFrom));
		checkValue(ledr, '0, "ledr at start of read pass");
		shown = '0;
		addr = 0;

		for (int i = 1; i <= ticks; i++) begin
			advanceTick(keysAt(i, own, other, otherFrom));
			// Odd ticks are readDo and latch a new byte
			// Even ticks are readSet and keep it
			if (i % 2 == 1) begin
				addr = (i - 1) / 2;
				shown = expectedLed(addr);
			end
			checkValue(ledr, shown,
				$sformatf("ledr at read tick %0d, address %0d", i, addr));
		end

		if (ticks == passTicks) begin
			advanceTick(keysIdle);
			checkValue(ledr, ledIdleCode, "ledr after read pass");
		end
	endtask

	// Behavior 1
	// Reset code during reset, idle code from the first tick on
	task automatic testResetState();
		$display("Test: reset state");
		holdReset();
		advanceTick(keysIdle);
		checkValue(ledr, ledIdleCode, "ledr at first tick after reset");
		// No buttons, stays idle
		repeat (3) begin
			advanceTick(keysIdle);
			checkValue(ledr, ledIdleCode, "ledr while idle");
		end
	endtask

	// Behavior 2
	// Fills addresses 0 to 127 with the descending pattern
	task automatic testWritePass();
		$display("Test: write pass");
		runWritePass(writeKey, noKey, 0);
	endtask

	// Behavior 3
	// Reads the pattern back onto the LEDs
	task automatic testReadBack();
		$display("Test: read-back");
		runReadPass(readKey, noKey, 0, passTicks);
	endtask

	// Both buttons down, read wins
	task automatic testReadPriority();
		$display("Test: read priority");
		runReadPass(readKey, writeKey, 0, passTicks);
	endtask

	// Behavior 4
	// Buttons pressed in the middle of a pass change nothing
	task automatic testIgnoredKeys();
		$display("Test: ignored keys");
		// Read button partway through a write
		runWritePass(writeKey, readKey, 50);
		// Write button partway through a read
		runReadPass(readKey, writeKey, 101, passTicks);
		// Memory still holds the pattern
		runReadPass(readKey, noKey, 0, passTicks);
	endtask

	// Behavior 5
	// Reset during a read, memory keeps its contents
	task automatic testResetInPass();
		$display("Test: reset in a pass");
		// Stop at the readDo of address 20
		runReadPass(readKey, noKey, 0, 41);
		@(posedge clk);
		rst <= 1'b1;
		key <= keysIdle;
		holdReset();
		advanceTick(keysIdle);
		checkValue(ledr, ledIdleCode, "ledr at first tick after reset in a pass");
		// Pattern survives the reset
		runReadPass(readKey, noKey, 0, passTicks);
	endtask

	// Test sequence
	initial begin
		$timeformat(-9, 0, " ns", 0);
		// Reset from time zero, buttons released
		rst <= 1'b1;
		key <= keysIdle;

		testResetState();
		testWritePass();
		testReadBack();
		testReadPriority();
		testIgnoredKeys();
		testResetInPass();

		$display("All tests passed");
		$finish;
	end

endmodule

// ==== sramModel.sv ====
/*
  Behavioral model of a 2048 x 16 asynchronous static RAM.
  Writes on clk edges while weN is low; reads combinationally while oeN is low.
  With the output disabled the read bus is zero instead of high impedance.
*/
module sramModel (
	input  logic                         clk,
	input  logic [sramPkg::addrBits-1:0] addr,
	input  logic [sramPkg::dataBits-1:0] writeData,
	input  logic                         oeN,
	input  logic                         weN,
	output logic [sramPkg::dataBits-1:0] readData
);

	// Storage array, one word per address
	logic [sramPkg::dataBits-1:0] mem [2**sramPkg::addrBits];

	// Power-up contents are all zero
	// Reset leaves the array alone
	initial begin
		for (int i = 0; i < 2**sramPkg::addrBits; i++) begin
			mem[i] = '0;
		end
	end

	// Write port
	// The word is rewritten on every edge that weN stays low
	always_ff @(posedge clk) begin
		if (!weN) begin
			mem[addr] <= writeData;
		end
	end

	// Read port, no clock involved
	// Disabled output reads as zero
	always_comb begin
		if (!oeN) begin
			readData = mem[addr];
		end else begin
			readData = '0;
		end
	end

endmodule

// ==== sramPkg.sv ====
/*
  Shared constants for the SRAM demonstrator.
  Bus widths, the range walked by the demo, LED codes and FSM encodings.
  Modules refer to these by scoped name.
*/
package sramPkg;

	// RAM geometry, 2048 x 16
	localparam int addrBits = 11;
	localparam int dataBits = 16;

	// Board LEDs, bits 9..2 show data and bits 1..0 show status
	localparam int ledCount = 10;

	// The demo covers addresses 0 to 127
	localparam logic [addrBits-1:0] lastAddr = 11'd127;

	// Value stored at address 0, one less for each later address
	localparam logic [dataBits-1:0] writeStart = 16'd127;

	// 2^23 clocks between ticks on the real board
	localparam int tickBitsDefault = 23;

	// Status codes shown on the LEDs
	localparam logic [ledCount-1:0] ledReset = 10'b00_0000_0001;
	localparam logic [ledCount-1:0] ledIdle = 10'b00_0000_0010;
	localparam logic [ledCount-1:0] ledWrite = 10'b00_0000_0011;

	// Controller FSM state codes
	localparam int stateBits = 3;
	localparam logic [stateBits-1:0] idle = 3'b000;
	localparam logic [stateBits-1:0] writeSet = 3'b001;
	localparam logic [stateBits-1:0] writeDo = 3'b011;
	localparam logic [stateBits-1:0] readSet = 3'b111;
	localparam logic [stateBits-1:0] readDo = 3'b110;

endpackage

// ==== tickGen.sv ====
/*
  Tick generator for the controller.
  A free-running counter raises tick for one clock each time it reaches all ones,
  so the slow FSM pace comes from an enable and everything stays on clk.
*/
module tickGen #(
	parameter int tickBits = sramPkg::tickBitsDefault
) (
	input  logic clk,
	input  logic rst,
	output logic tick
);

	logic [tickBits-1:0] count;

	// Counts every clock and wraps on its own
	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

	// High in the last cycle before the wrap
	// First tick lands on the 2^tickBits-th clock after reset
	assign tick = &count;

endmodule
